// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef logic [31:0] word_t;     // Data word and byte address
    typedef logic [3:0]  reg_idx_t;  // r0 .. r15
    typedef logic [15:0] imm_t;      // Raw immediate field, inst[23:8]
    typedef logic [23:0] hex_t;      // Six hex digits of the display register

    // Primary opcode in inst[31:26]
    typedef enum logic [5:0] {
        ALUR = 6'b000000,
        BEQ  = 6'b001000,
        BLT  = 6'b001001,
        BLE  = 6'b001010,
        BNE  = 6'b001011,
        JAL  = 6'b001100,
        LW   = 6'b010010,
        SW   = 6'b011010,
        ADDI = 6'b100000,
        ANDI = 6'b100100,
        ORI  = 6'b100101,
        XORI = 6'b100110
    } op1_t;

    // Secondary opcode in inst[25:18], only meaningful for ALUR
    typedef enum logic [7:0] {
        EQ   = 8'b00001000,
        LT   = 8'b00001001,
        LE   = 8'b00001010,
        NE   = 8'b00001011,
        ADD  = 8'b00100000,
        AND  = 8'b00100100,
        OR   = 8'b00100101,
        XOR  = 8'b00100110,
        SUB  = 8'b00101000,
        NAND = 8'b00101100,
        NOR  = 8'b00101101,
        NXOR = 8'b00101110,
        RSHF = 8'b00110000,
        LSHF = 8'b00110001
    } op2_t;

    localparam word_t INST_SIZE = 32'd4;
    localparam word_t START_PC  = 32'h0000_0100;
    localparam word_t ADDR_HEX  = 32'hFFFF_F000;  // Memory-mapped display register
    localparam hex_t  HEX_RESET = 24'hFE_DEAD;

endpackage

// ==== common/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    // Second ALU operand
    typedef enum logic [1:0] {
        RT     = 2'd0,  // Register value
        IMM    = 2'd1,  // Sign-extended immediate
        IMM_X4 = 2'd2   // Immediate as a word offset
    } alu_src_t;

    // Register writeback source
    typedef enum logic [1:0] {
        PC  = 2'd0,  // Return address for JAL
        MEM = 2'd1,
        ALU = 2'd2
    } wb_src_t;

    localparam int IMEM_WORDS = 16384;
    localparam int DMEM_WORDS = 16384;

    typedef logic [$clog2(IMEM_WORDS)-1:0] imem_idx_t;
    typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_idx_t;

endpackage

// ==== pipeline/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::reg_idx_t rs_idx,
    input  cpu_isa_pkg::reg_idx_t rt_idx,
    output cpu_isa_pkg::word_t    rs_val,
    output cpu_isa_pkg::word_t    rt_val,
    input  logic                  wb_we,
    input  cpu_isa_pkg::reg_idx_t wb_idx,
    input  cpu_isa_pkg::word_t    wb_val
);

    cpu_isa_pkg::word_t regs [2 ** $bits(cpu_isa_pkg::reg_idx_t)];

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    // Falling-edge write, so decode reads the new value later in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wb_we) begin
            regs[wb_idx] <= wb_val;
        end
    end

endmodule

// ==== pipeline/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    prog_we,
    input  cpu_pipe_pkg::imem_idx_t prog_addr,
    input  cpu_isa_pkg::word_t      prog_data,
    input  logic                    stall,
    input  logic                    mispredict,
    input  cpu_isa_pkg::word_t      good_pc,
    output cpu_isa_pkg::word_t      inst,
    output cpu_isa_pkg::word_t      pc_next
);

    cpu_isa_pkg::word_t imem [cpu_pipe_pkg::IMEM_WORDS];
    cpu_isa_pkg::word_t pc;
    cpu_isa_pkg::word_t pc_plus;

    assign pc_plus = pc + cpu_isa_pkg::INST_SIZE;  // Always predict not taken

    // Program load port, driven while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= cpu_isa_pkg::START_PC;
            inst    <= '0;
            pc_next <= '0;
        end else if (mispredict) begin
            // Redirect wins over a pending stall
            pc      <= good_pc;
            inst    <= '0;  // Flushed slot
            pc_next <= '0;
        end else if (!stall) begin
            pc      <= pc_plus;
            inst    <= imem[cpu_pipe_pkg::imem_idx_t'(pc >> 2)];
            pc_next <= pc_plus;
        end
    end

endmodule

// ==== pipeline/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_isa_pkg::word_t     inst,
    input  cpu_isa_pkg::word_t     pc_next,
    input  logic                   mispredict,
    input  cpu_isa_pkg::word_t     rs_val,
    input  cpu_isa_pkg::word_t     rt_val,
    output cpu_isa_pkg::reg_idx_t  rs_idx,
    output cpu_isa_pkg::reg_idx_t  rt_idx,
    input  cpu_isa_pkg::reg_idx_t  dst_ex,
    input  cpu_isa_pkg::reg_idx_t  dst_mem,
    input  logic                   we_ex,
    input  logic                   we_mem,
    output logic                   stall,
    output cpu_isa_pkg::op1_t      op1,
    output cpu_isa_pkg::op2_t      op2,
    output cpu_pipe_pkg::alu_src_t alu_src,
    output cpu_pipe_pkg::wb_src_t  wb_src,
    output logic                   reg_we,
    output logic                   mem_we,
    output cpu_isa_pkg::reg_idx_t  dst,
    output cpu_isa_pkg::word_t     rs_q,
    output cpu_isa_pkg::word_t     rt_q,
    output cpu_isa_pkg::word_t     imm_q,
    output cpu_isa_pkg::word_t     pc_q
);

    cpu_isa_pkg::op1_t      op1_w;
    cpu_isa_pkg::reg_idx_t  rd_idx;
    cpu_isa_pkg::imm_t      imm_w;
    cpu_pipe_pkg::alu_src_t alu_src_w;
    cpu_pipe_pkg::wb_src_t  wb_src_w;
    logic                   reg_we_w;
    logic                   mem_we_w;
    logic                   rd_dst;   // ALUR writes rd, the rest write rt
    logic                   uses_rt;
    logic                   bubble;

    assign op1_w  = cpu_isa_pkg::op1_t'(inst[31:26]);
    assign imm_w  = inst[23:8];
    assign rd_idx = inst[11:8];
    assign rs_idx = inst[7:4];
    assign rt_idx = inst[3:0];

    always_comb begin
        alu_src_w = cpu_pipe_pkg::RT;
        wb_src_w  = cpu_pipe_pkg::ALU;
        reg_we_w  = 1'b0;
        mem_we_w  = 1'b0;
        rd_dst    = 1'b0;
        uses_rt   = 1'b0;
        case (op1_w)
            cpu_isa_pkg::ALUR: begin
                reg_we_w = 1'b1;
                rd_dst   = 1'b1;
                uses_rt  = 1'b1;
            end
            cpu_isa_pkg::BEQ, cpu_isa_pkg::BLT, cpu_isa_pkg::BLE, cpu_isa_pkg::BNE: begin
                uses_rt = 1'b1;
            end
            cpu_isa_pkg::JAL: begin
                alu_src_w = cpu_pipe_pkg::IMM_X4;  // Jump offset rides on the ALU operand
                wb_src_w  = cpu_pipe_pkg::PC;
                reg_we_w  = 1'b1;
            end
            cpu_isa_pkg::LW: begin
                alu_src_w = cpu_pipe_pkg::IMM;
                wb_src_w  = cpu_pipe_pkg::MEM;
                reg_we_w  = 1'b1;
            end
            cpu_isa_pkg::SW: begin
                alu_src_w = cpu_pipe_pkg::IMM;
                mem_we_w  = 1'b1;
                uses_rt   = 1'b1;  // Store data
            end
            cpu_isa_pkg::ADDI, cpu_isa_pkg::ANDI, cpu_isa_pkg::ORI, cpu_isa_pkg::XORI: begin
                alu_src_w = cpu_pipe_pkg::IMM;
                reg_we_w  = 1'b1;
            end
            default: ;  // Unknown opcode passes down as a bubble
        endcase
    end

    // Source register still owed a write by an older instruction
    function automatic logic pending(input cpu_isa_pkg::reg_idx_t idx);
        return (idx != '0) && ((reg_we && dst == idx) ||
                               (we_ex && dst_ex == idx) ||
                               (we_mem && dst_mem == idx));
    endfunction

    always_comb begin
        stall = pending(rs_idx) || (uses_rt && pending(rt_idx));
    end

    assign bubble = stall || mispredict;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op1    <= cpu_isa_pkg::ALUR;
            reg_we <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            op1    <= bubble ? cpu_isa_pkg::ALUR : op1_w;  // ALUR never branches
            reg_we <= reg_we_w && !bubble;
            mem_we <= mem_we_w && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        op2     <= cpu_isa_pkg::op2_t'(inst[25:18]);
        alu_src <= alu_src_w;
        wb_src  <= wb_src_w;
        dst     <= rd_dst ? rd_idx : rt_idx;
        rs_q    <= rs_val;
        rt_q    <= rt_val;
        imm_q   <= {{($bits(cpu_isa_pkg::word_t) - $bits(imm_w)){imm_w[15]}}, imm_w};
        pc_q    <= pc_next;
    end

endmodule

// ==== pipeline/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_isa_pkg::op1_t      op1,
    input  cpu_isa_pkg::op2_t      op2,
    input  cpu_pipe_pkg::alu_src_t alu_src,
    input  cpu_pipe_pkg::wb_src_t  wb_src,
    input  logic                   reg_we,
    input  logic                   mem_we,
    input  cpu_isa_pkg::reg_idx_t  dst,
    input  cpu_isa_pkg::word_t     rs_val,
    input  cpu_isa_pkg::word_t     rt_val,
    input  cpu_isa_pkg::word_t     imm,
    input  cpu_isa_pkg::word_t     pc,
    output logic                   mispredict,
    output cpu_isa_pkg::word_t     good_pc,
    output cpu_isa_pkg::word_t     alu_q,
    output cpu_isa_pkg::word_t     store_q,
    output cpu_isa_pkg::reg_idx_t  dst_q,
    output logic                   reg_we_q,
    output logic                   mem_we_q,
    output cpu_pipe_pkg::wb_src_t  wb_src_q,
    output cpu_isa_pkg::word_t     pc_q
);

    cpu_isa_pkg::word_t offset;
    cpu_isa_pkg::word_t opb;
    cpu_isa_pkg::word_t alu_w;
    logic               taken;

    assign offset = imm << 2;

    always_comb begin
        case (alu_src)
            cpu_pipe_pkg::IMM:    opb = imm;
            cpu_pipe_pkg::IMM_X4: opb = offset;
            default:              opb = rt_val;
        endcase
    end

    always_comb begin
        case (op1)
            cpu_isa_pkg::ALUR: begin
                case (op2)
                    cpu_isa_pkg::EQ:   alu_w = cpu_isa_pkg::word_t'(rs_val == opb);
                    cpu_isa_pkg::LT:   alu_w = cpu_isa_pkg::word_t'($signed(rs_val) < $signed(opb));
                    cpu_isa_pkg::LE:   alu_w = cpu_isa_pkg::word_t'($signed(rs_val) <= $signed(opb));
                    cpu_isa_pkg::NE:   alu_w = cpu_isa_pkg::word_t'(rs_val != opb);
                    cpu_isa_pkg::ADD:  alu_w = rs_val + opb;
                    cpu_isa_pkg::AND:  alu_w = rs_val & opb;
                    cpu_isa_pkg::OR:   alu_w = rs_val | opb;
                    cpu_isa_pkg::XOR:  alu_w = rs_val ^ opb;
                    cpu_isa_pkg::SUB:  alu_w = rs_val - opb;
                    cpu_isa_pkg::NAND: alu_w = ~(rs_val & opb);
                    cpu_isa_pkg::NOR:  alu_w = ~(rs_val | opb);
                    cpu_isa_pkg::NXOR: alu_w = ~(rs_val ^ opb);
                    cpu_isa_pkg::RSHF: alu_w = cpu_isa_pkg::word_t'($signed(rs_val) >>> opb);
                    cpu_isa_pkg::LSHF: alu_w = rs_val << opb;
                    default:           alu_w = '0;
                endcase
            end
            cpu_isa_pkg::LW, cpu_isa_pkg::SW, cpu_isa_pkg::ADDI: alu_w = rs_val + opb;
            cpu_isa_pkg::ANDI: alu_w = rs_val & opb;
            cpu_isa_pkg::ORI:  alu_w = rs_val | opb;
            cpu_isa_pkg::XORI: alu_w = rs_val ^ opb;
            default:           alu_w = '0;
        endcase
    end

    // Fetch predicts not taken, so every taken branch and every JAL redirects
    always_comb begin
        case (op1)
            cpu_isa_pkg::BEQ: taken = rs_val == rt_val;
            cpu_isa_pkg::BLT: taken = $signed(rs_val) < $signed(rt_val);
            cpu_isa_pkg::BLE: taken = $signed(rs_val) <= $signed(rt_val);
            cpu_isa_pkg::BNE: taken = rs_val != rt_val;
            cpu_isa_pkg::JAL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign mispredict = taken;
    assign good_pc    = (op1 == cpu_isa_pkg::JAL) ? rs_val + opb : pc + offset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_we_q <= 1'b0;
            mem_we_q <= 1'b0;
        end else begin
            reg_we_q <= reg_we;
            mem_we_q <= mem_we;
        end
    end

    always_ff @(posedge clk) begin
        alu_q    <= alu_w;
        store_q  <= rt_val;
        dst_q    <= dst;
        wb_src_q <= wb_src;
        pc_q     <= pc;  // JAL return address
    end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::word_t    alu,
    input  cpu_isa_pkg::word_t    store,
    input  cpu_isa_pkg::reg_idx_t dst,
    input  logic                  reg_we,
    input  logic                  mem_we,
    input  cpu_pipe_pkg::wb_src_t wb_src,
    input  cpu_isa_pkg::word_t    pc,
    output cpu_isa_pkg::reg_idx_t dst_ex,
    output logic                  we_ex,
    output cpu_isa_pkg::reg_idx_t dst_mem,
    output logic                  we_mem,
    output logic                  wb_we,
    output cpu_isa_pkg::reg_idx_t wb_idx,
    output cpu_isa_pkg::word_t    wb_val,
    output cpu_isa_pkg::hex_t     hex_value,
    output logic                  hex_strobe
);

    cpu_isa_pkg::word_t      dmem [cpu_pipe_pkg::DMEM_WORDS];
    cpu_pipe_pkg::dmem_idx_t daddr;
    cpu_isa_pkg::word_t      wb_sel;
    logic                    hex_wr;

    assign daddr  = cpu_pipe_pkg::dmem_idx_t'(alu >> 2);
    assign hex_wr = mem_we && (alu == cpu_isa_pkg::ADDR_HEX);

    // Hazard info for decode, from the EX latch and from our own latch
    assign dst_ex  = dst;
    assign we_ex   = reg_we;
    assign dst_mem = wb_idx;
    assign we_mem  = wb_we;

    always_ff @(posedge clk) begin
        if (mem_we && !hex_wr) begin
            dmem[daddr] <= store;
        end
    end

    always_comb begin
        case (wb_src)
            cpu_pipe_pkg::PC:  wb_sel = pc;
            cpu_pipe_pkg::MEM: wb_sel = dmem[daddr];
            default:           wb_sel = alu;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we      <= 1'b0;
            hex_value  <= cpu_isa_pkg::HEX_RESET;
            hex_strobe <= 1'b0;
        end else begin
            wb_we      <= reg_we;
            hex_strobe <= hex_wr;  // One cycle per store
            if (hex_wr) begin
                hex_value <= cpu_isa_pkg::hex_t'(store);  // Low 24 bits shown
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_idx <= dst;
        wb_val <= wb_sel;
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    prog_we,
    input  cpu_pipe_pkg::imem_idx_t prog_addr,
    input  cpu_isa_pkg::word_t      prog_data,
    output cpu_isa_pkg::hex_t       hex_value,
    output logic                    hex_strobe
);

    cpu_isa_pkg::word_t     fe_inst;
    cpu_isa_pkg::word_t     fe_pc_next;
    logic                   stall;
    logic                   mispredict;
    cpu_isa_pkg::word_t     good_pc;
    cpu_isa_pkg::reg_idx_t  rs_idx;
    cpu_isa_pkg::reg_idx_t  rt_idx;
    cpu_isa_pkg::word_t     rs_val;
    cpu_isa_pkg::word_t     rt_val;
    cpu_isa_pkg::reg_idx_t  dst_ex;
    cpu_isa_pkg::reg_idx_t  dst_mem;
    logic                   we_ex;
    logic                   we_mem;
    cpu_isa_pkg::op1_t      id_op1;
    cpu_isa_pkg::op2_t      id_op2;
    cpu_pipe_pkg::alu_src_t id_alu_src;
    cpu_pipe_pkg::wb_src_t  id_wb_src;
    logic                   id_reg_we;
    logic                   id_mem_we;
    cpu_isa_pkg::reg_idx_t  id_dst;
    cpu_isa_pkg::word_t     id_rs;
    cpu_isa_pkg::word_t     id_rt;
    cpu_isa_pkg::word_t     id_imm;
    cpu_isa_pkg::word_t     id_pc;
    cpu_isa_pkg::word_t     ex_alu;
    cpu_isa_pkg::word_t     ex_store;
    cpu_isa_pkg::reg_idx_t  ex_dst;
    logic                   ex_reg_we;
    logic                   ex_mem_we;
    cpu_pipe_pkg::wb_src_t  ex_wb_src;
    cpu_isa_pkg::word_t     ex_pc;
    logic                   wb_we;
    cpu_isa_pkg::reg_idx_t  wb_idx;
    cpu_isa_pkg::word_t     wb_val;

    fetch_stage i_fetch (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .stall      (stall),
        .mispredict (mispredict),
        .good_pc    (good_pc),
        .inst       (fe_inst),
        .pc_next    (fe_pc_next)
    );

    decode_stage i_decode (
        .clk        (clk),
        .reset      (reset),
        .inst       (fe_inst),
        .pc_next    (fe_pc_next),
        .mispredict (mispredict),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .dst_ex     (dst_ex),
        .dst_mem    (dst_mem),
        .we_ex      (we_ex),
        .we_mem     (we_mem),
        .stall      (stall),
        .op1        (id_op1),
        .op2        (id_op2),
        .alu_src    (id_alu_src),
        .wb_src     (id_wb_src),
        .reg_we     (id_reg_we),
        .mem_we     (id_mem_we),
        .dst        (id_dst),
        .rs_q       (id_rs),
        .rt_q       (id_rt),
        .imm_q      (id_imm),
        .pc_q       (id_pc)
    );

    register_file i_regs (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb_we  (wb_we),
        .wb_idx (wb_idx),
        .wb_val (wb_val)
    );

    execute_stage i_execute (
        .clk        (clk),
        .reset      (reset),
        .op1        (id_op1),
        .op2        (id_op2),
        .alu_src    (id_alu_src),
        .wb_src     (id_wb_src),
        .reg_we     (id_reg_we),
        .mem_we     (id_mem_we),
        .dst        (id_dst),
        .rs_val     (id_rs),
        .rt_val     (id_rt),
        .imm        (id_imm),
        .pc         (id_pc),
        .mispredict (mispredict),
        .good_pc    (good_pc),
        .alu_q      (ex_alu),
        .store_q    (ex_store),
        .dst_q      (ex_dst),
        .reg_we_q   (ex_reg_we),
        .mem_we_q   (ex_mem_we),
        .wb_src_q   (ex_wb_src),
        .pc_q       (ex_pc)
    );

    memory_stage i_memory (
        .clk        (clk),
        .reset      (reset),
        .alu        (ex_alu),
        .store      (ex_store),
        .dst        (ex_dst),
        .reg_we     (ex_reg_we),
        .mem_we     (ex_mem_we),
        .wb_src     (ex_wb_src),
        .pc         (ex_pc),
        .dst_ex     (dst_ex),
        .we_ex      (we_ex),
        .dst_mem    (dst_mem),
        .we_mem     (we_mem),
        .wb_we      (wb_we),
        .wb_idx     (wb_idx),
        .wb_val     (wb_val),
        .hex_value  (hex_value),
        .hex_strobe (hex_strobe)
    );

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;

    localparam int                CLK_HALF     = 4;     // 8 ns period
    localparam int                DRIVE_DELAY  = 1;
    localparam int                RESET_CYCLES = 10;
    localparam int                WAIT_CYCLES  = 2000;
    localparam int                QUIET_CYCLES = 100;   // Halt loop must stay silent
    localparam cpu_isa_pkg::hex_t HEX_AFTER_RESET = 24'hFE_DEAD;

    logic                    clk;
    logic                    reset;
    logic                    prog_we;
    cpu_pipe_pkg::imem_idx_t prog_addr;
    cpu_isa_pkg::word_t      prog_data;
    cpu_isa_pkg::hex_t       hex_value;
    logic                    hex_strobe;

    cpu_isa_pkg::word_t prog_words [$];
    cpu_isa_pkg::hex_t  expected_hex [$];

    cpu_top i_cpu_top (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .hex_value  (hex_value),
        .hex_strobe (hex_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_hex(input cpu_isa_pkg::hex_t got, input cpu_isa_pkg::hex_t want,
                             input string what);
        if (got !== want) begin
            stop_failed($sformatf("[ERROR] %0t ns: %s: hex_value is %06h, expected %06h",
                                  $time, what, got, want));
        end
    endtask

    task automatic check_strobe(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_failed($sformatf("[ERROR] %0t ns: %s: hex_strobe is %b, expected %b",
                                  $time, what, got, want));
        end
    endtask

    // P lines go to the program, E lines to the expected HEX sequence
    task automatic read_stim();
        int                 fd;
        int                 n;
        string              line;
        string              rest;
        byte                tag;
        cpu_isa_pkg::word_t value;
        fd = $fopen("testbench/cpu_stim.txt", "r");
        if (fd == 0) begin
            stop_failed("Could not open the stimulus file testbench/cpu_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    tag = line.getc(0);
                    if (tag == "P" || tag == "E") begin
                        rest = line.substr(1, line.len() - 1);
                        n = $sscanf(rest, "%h", value);
                        if (n != 1) begin
                            stop_failed({"Malformed line in the stimulus file: ", line});
                        end else if (tag == "P") begin
                            prog_words.push_back(value);
                        end else begin
                            expected_hex.push_back(cpu_isa_pkg::hex_t'(value));
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One word per clock through the load port, starting at the reset PC
    task automatic load_program();
        int i;
        for (i = 0; i < prog_words.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            prog_we   = 1'b1;
            prog_addr = cpu_pipe_pkg::imem_idx_t'((cpu_isa_pkg::START_PC >> 2) + 32'(i));
            prog_data = prog_words[i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        prog_we = 1'b0;
    endtask

    task automatic wait_hex_write(input int index);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!hex_strobe && cycles < WAIT_CYCLES);
        if (!hex_strobe) begin
            stop_failed($sformatf("No HEX write arrived within %0d cycles for store number %0d",
                                  WAIT_CYCLES, index));
        end
    endtask

    initial begin
        int idx;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_stim();
        if (prog_words.size() == 0 || expected_hex.size() == 0) begin
            stop_failed("The stimulus file holds no program or no expected values");
        end
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_hex(hex_value, HEX_AFTER_RESET, "during reset");
        check_strobe(hex_strobe, 1'b0, "during reset");
        reset = 1'b0;

        @(posedge clk);
        #DRIVE_DELAY;
        check_hex(hex_value, HEX_AFTER_RESET, "before the first store");
        check_strobe(hex_strobe, 1'b0, "before the first store");

        for (idx = 0; idx < expected_hex.size(); idx++) begin
            wait_hex_write(idx);
            check_hex(hex_value, expected_hex[idx], $sformatf("store number %0d", idx));
        end

        // Flushed markers after the halt loop must never reach HEX
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_strobe(hex_strobe, 1'b0, "after the last expected store");
        end
        check_hex(hex_value, expected_hex[expected_hex.size() - 1], "final value");
        $display("Test OK");
        $finish;
    end

endmodule

// ==== testbench/cpu_stim.txt ====
# Column 1: P = program word loaded from 0x100 upward, E = next expected HEX value
# Column 2: hex value; the rest of the line is a note with the address and mnemonic
P 80123401  100 ADDI r1, r0, 0x1234
P 80876502  104 ADDI r2, r0, 0x8765  (r2 = 0xFFFF8765)
P 80000404  108 ADDI r4, r0, 4
P 800BAD0B  10C ADDI r11, r0, 0x0BAD  (wrong-path marker)
P 00800312  110 ADD r3, r1, r2
P 68F00003  114 SW r3 -> HEX
E FF9999
P 00900312  118 AND r3, r1, r2
P 68F00003  11C SW r3 -> HEX
E 000224
P 00940312  120 OR r3, r1, r2
P 68F00003  124 SW r3 -> HEX
E FF9775
P 00980312  128 XOR r3, r1, r2
P 68F00003  12C SW r3 -> HEX
E FF9551
P 00A00312  130 SUB r3, r1, r2
P 68F00003  134 SW r3 -> HEX
E 008ACF
P 00B00312  138 NAND r3, r1, r2
P 68F00003  13C SW r3 -> HEX
E FFFDDB
P 00B40312  140 NOR r3, r1, r2
P 68F00003  144 SW r3 -> HEX
E 00688A
P 00B80312  148 NXOR r3, r1, r2
P 68F00003  14C SW r3 -> HEX
E 006AAE
P 00C00324  150 RSHF r3, r2, r4
P 68F00003  154 SW r3 -> HEX
E FFF876
P 00C40314  158 LSHF r3, r1, r4
P 68F00003  15C SW r3 -> HEX
E 012340
P 00200311  160 EQ r3, r1, r1
P 68F00003  164 SW r3 -> HEX
E 000001
P 00240321  168 LT r3, r2, r1  (signed)
P 68F00003  16C SW r3 -> HEX
E 000001
P 00280312  170 LE r3, r1, r2  (signed)
P 68F00003  174 SW r3 -> HEX
E 000000
P 002C0312  178 NE r3, r1, r2
P 68F00003  17C SW r3 -> HEX
E 000001
P 80FFF015  180 ADDI r5, r1, -16
P 68F00005  184 SW r5 -> HEX
E 001224
P 90FF0F26  188 ANDI r6, r2, 0xFF0F
P 68F00006  18C SW r6 -> HEX
E FF8705
P 94800017  190 ORI r7, r1, 0x8000
P 68F00007  194 SW r7 -> HEX
E FF9234
P 98FFFF18  198 XORI r8, r1, 0xFFFF
P 68F00008  19C SW r8 -> HEX
E FFEDCB
P 68003C47  1A0 SW r7, 0x3C(r4)  (data word 0x40)
P 48004009  1A4 LW r9, 0x40(r0)
P 68F00009  1A8 SW r9 -> HEX
E FF9234
P 20000112  1AC BEQ r1, r2, +1  (not taken)
P 68F00001  1B0 SW r1 -> HEX
E 001234
P 20000211  1B4 BEQ r1, r1, +2  (taken to 1C0)
P 68F0000B  1B8 SW r11 -> HEX  (flushed)
P 68F0000B  1BC SW r11 -> HEX  (flushed)
P 68F00002  1C0 SW r2 -> HEX
E FF8765
P 24000112  1C4 BLT r1, r2, +1  (not taken)
P 68F00004  1C8 SW r4 -> HEX
E 000004
P 24000221  1CC BLT r2, r1, +2  (taken to 1D8)
P 68F0000B  1D0 SW r11 -> HEX  (flushed)
P 68F0000B  1D4 SW r11 -> HEX  (flushed)
P 68F00005  1D8 SW r5 -> HEX
E 001224
P 28000112  1DC BLE r1, r2, +1  (not taken)
P 68F00006  1E0 SW r6 -> HEX
E FF8705
P 28000211  1E4 BLE r1, r1, +2  (taken to 1F0)
P 68F0000B  1E8 SW r11 -> HEX  (flushed)
P 68F0000B  1EC SW r11 -> HEX  (flushed)
P 68F00008  1F0 SW r8 -> HEX
E FFEDCB
P 2C000111  1F4 BNE r1, r1, +1  (not taken)
P 68F00001  1F8 SW r1 -> HEX
E 001234
P 2C000212  1FC BNE r1, r2, +2  (taken to 208)
P 68F0000B  200 SW r11 -> HEX  (flushed)
P 68F0000B  204 SW r11 -> HEX  (flushed)
P 68F00002  208 SW r2 -> HEX
E FF8765
P 3000880C  20C JAL r12, r0, 0x88  (to 220, r12 = 210)
P 68F0000D  210 SW r13 -> HEX  (return point)
P 20FFFF00  214 BEQ r0, r0, -1  (halt loop)
P 68F0000B  218 SW r11 -> HEX  (flushed)
P 68F0000B  21C SW r11 -> HEX  (flushed)
P 68F0000C  220 SW r12 -> HEX  (subroutine)
E 000210
P 300000CD  224 JAL r13, r12, 0  (back to 210, r13 = 228)
E 000228
P 68F0000B  228 SW r11 -> HEX  (flushed)
P 68F0000B  22C SW r11 -> HEX  (flushed)

// ==== sim.f ====
common/cpu_isa_pkg.sv
common/cpu_pipe_pkg.sv
pipeline/register_file.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
testbench/tb_cpu.sv

// ==== Makefile ====
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
